// ==== logic/soc_pkg.sv ====
// ---------------------------------------
// request and response types of the ramio port
// I/O sits at the top two word addresses
// RAM aliases every other address
// ---------------------------------------
package soc_pkg;

  // one access request from host or boot loader
  typedef struct packed {
    logic        enable;      // one cycle per request
    logic [2:0]  read_type;   // RD_* code
    logic [1:0]  write_type;  // WR_* code
    logic [31:0] address;     // byte address
    logic [31:0] data_in;     // write data, low bits used for B/H
  } ramio_req_t;

  // response back to the requester
  typedef struct packed {
    logic [31:0] data_out;
    logic        data_out_ready;  // one cycle pulse
    logic        busy;            // request ignored while high
  } ramio_rsp_t;

  // ---------------------------------------
  // read types, bit 2 set means zero extend
  // ---------------------------------------
  localparam logic [2:0] RD_NONE = 3'b000;
  localparam logic [2:0] RD_B    = 3'b001;
  localparam logic [2:0] RD_H    = 3'b010;
  localparam logic [2:0] RD_W    = 3'b011;
  localparam logic [2:0] RD_BU   = 3'b101;
  localparam logic [2:0] RD_HU   = 3'b110;

  // write types
  localparam logic [1:0] WR_NONE = 2'b00;
  localparam logic [1:0] WR_B    = 2'b01;
  localparam logic [1:0] WR_H    = 2'b10;
  localparam logic [1:0] WR_W    = 2'b11;

  // ---------------------------------------
  // memory mapped I/O
  // ---------------------------------------
  localparam logic [31:0] UART_TX_ADDR = 32'hFFFF_FFFC;  // byte write sends it
  localparam logic [31:0] LED_ADDR     = 32'hFFFF_FFF8;  // low 4 bits

  localparam logic [7:0] FLASH_READ_CMD = 8'h03;  // plain SPI READ

endpackage

// ==== logic/baud_timer.sv ====
// ---------------------------------------
// bit period counter for the UART
// ClocksPerBit must be 2 or more
// run has to fall on a tick edge or later
// ---------------------------------------
`timescale 1ns/1ps

module baud_timer #(
  parameter int unsigned ClocksPerBit = 8
) (
  input  logic clk,
  input  logic arst_n,
  input  logic run,   // high while a frame is on the line
  output logic tick   // one cycle per bit boundary
);

  localparam int unsigned CntWidth = $clog2(ClocksPerBit);
  localparam logic [CntWidth-1:0] CntLast = CntWidth'(ClocksPerBit - 1);

  logic [CntWidth-1:0] cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (!run || cnt == CntLast) begin
      cnt <= '0;  // restart when stopped or at wrap
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign tick = (cnt == CntLast);  // not gated, see run rule above

  // uart_tx must release run together with the last tick
  a_no_idle_tick: assert property (@(posedge clk) disable iff (!arst_n) !run |-> !tick);

endmodule

// ==== logic/uart_tx.sv ====
// ---------------------------------------
// 8N1 transmitter, LSB first
// send is taken only while not busy
// busy covers the stop bit
// ---------------------------------------
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       send,     // load a new frame
  input  logic [7:0] data,
  input  logic       tick,     // bit boundary from baud_timer
  output logic       uart_tx,  // serial line, idles high
  output logic       busy
);

  logic [9:0] frame;    // bit 0 is on the line
  logic [3:0] bit_cnt;  // bits already sent

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      frame   <= '1;  // line high out of reset
      bit_cnt <= '0;
      busy    <= 1'b0;
    end else if (send && !busy) begin
      frame   <= {1'b1, data, 1'b0};  // stop, data, start
      bit_cnt <= '0;
      busy    <= 1'b1;
    end else if (busy && tick) begin
      frame <= {1'b1, frame[9:1]};  // fill with ones
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;  // stop bit done
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign uart_tx = frame[0];

  // ---------------------------------------
  // checks
  // ---------------------------------------
  // after ten shifts only ones remain in the frame
  a_idle_high: assert property (@(posedge clk) disable iff (!arst_n) !busy |-> uart_tx);

endmodule

// ==== logic/flash_reader.sv ====
// ---------------------------------------
// SPI mode 0 reader, READ from address 0
// one SPI bit per 2 clocks
// start is ignored while a transfer runs
// ---------------------------------------
`timescale 1ns/1ps

module flash_reader import soc_pkg::*; #(
  parameter int unsigned FlashTransferBytes = 4096
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       start,
  output logic [7:0] byte_data,   // valid with byte_valid
  output logic       byte_valid,
  output logic       done,        // after last byte
  output logic       flash_clk,
  output logic       flash_mosi,
  output logic       flash_cs,
  input  logic       flash_miso
);

  localparam int unsigned ByteCntWidth = $clog2(FlashTransferBytes + 1);

  typedef enum logic [1:0] {IDLE, CMD, DATA} state_t;

  state_t                  state;
  logic [31:0]             cmd_sr;    // opcode and address, MSB first
  logic [4:0]              cmd_cnt;
  logic [2:0]              bit_cnt;   // bit within byte
  logic [ByteCntWidth-1:0] byte_cnt;
  logic [7:0]              rx_sr;

  assign flash_mosi = cmd_sr[31];
  assign byte_data  = rx_sr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      flash_cs   <= 1'b1;
      flash_clk  <= 1'b0;
      cmd_sr     <= '0;
      cmd_cnt    <= '0;
      bit_cnt    <= '0;
      byte_cnt   <= '0;
      byte_valid <= 1'b0;
      done       <= 1'b0;
    end else begin
      byte_valid <= 1'b0;  // pulses
      done       <= 1'b0;
      case (state)
        IDLE: if (start) begin
          flash_cs <= 1'b0;
          cmd_sr   <= {FLASH_READ_CMD, 24'h00_0000};
          cmd_cnt  <= '0;
          bit_cnt  <= '0;
          byte_cnt <= '0;
          state    <= CMD;
        end
        CMD: begin
          flash_clk <= ~flash_clk;
          if (flash_clk) begin  // falling edge, next bit out
            cmd_sr  <= {cmd_sr[30:0], 1'b0};
            cmd_cnt <= cmd_cnt + 1'b1;
            if (cmd_cnt == 5'd31) state <= DATA;
          end
        end
        DATA: begin
          flash_clk <= ~flash_clk;
          if (!flash_clk) begin  // rising edge, miso sampled
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              byte_valid <= 1'b1;
              byte_cnt   <= byte_cnt + 1'b1;
            end
          end else if (byte_cnt == ByteCntWidth'(FlashTransferBytes)) begin
            flash_cs <= 1'b1;  // clock back low on this edge too
            done     <= 1'b1;
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // receive shifter
  always_ff @(posedge clk) begin
    if (state == DATA && !flash_clk) rx_sr <= {rx_sr[6:0], flash_miso};
  end

  // one continuous transfer, chip select never drops early
  a_cs_held: assert property (@(posedge clk) disable iff (!arst_n)
    (state == IDLE && start) |=> !flash_cs until done);

endmodule

// ==== logic/boot_loader.sv ====
// ---------------------------------------
// waits, copies the flash image to RAM, then
// hands the port to the host
// StartupWaitCycles must be 1 or more
// ---------------------------------------
`timescale 1ns/1ps

module boot_loader import soc_pkg::*; #(
  parameter int unsigned StartupWaitCycles = 1_000_000
) (
  input  logic       clk,
  input  logic       arst_n,
  input  ramio_req_t host_req,
  output ramio_rsp_t host_rsp,
  output ramio_req_t mem_req,
  input  ramio_rsp_t mem_rsp,
  output logic       flash_start,
  input  logic [7:0] flash_byte,
  input  logic       flash_byte_valid,
  input  logic       flash_done,
  output logic       boot_done
);

  localparam int unsigned WaitWidth = $clog2(StartupWaitCycles + 1);

  typedef enum logic [1:0] {WAIT, READ, WRITE, RUN} state_t;

  state_t               state;
  logic [WaitWidth-1:0] wait_cnt;
  logic [31:0]          asm_word;   // bytes enter at the top
  logic [1:0]           byte_idx;
  logic [31:0]          hold_word;  // full word waiting for RAM
  logic [31:0]          word_addr;
  logic                 flash_end;  // done pulse seen
  logic                 word_full;
  logic                 accepted;
  ramio_req_t           boot_req;

  assign word_full = flash_byte_valid && byte_idx == 2'd3;
  assign accepted  = (state == WRITE) && !mem_rsp.busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= WAIT;
      wait_cnt    <= '0;
      byte_idx    <= '0;
      word_addr   <= '0;
      flash_start <= 1'b0;
      flash_end   <= 1'b0;
    end else begin
      flash_start <= 1'b0;
      if (flash_byte_valid) byte_idx <= byte_idx + 1'b1;
      if (flash_done) flash_end <= 1'b1;
      case (state)
        WAIT: begin
          if (wait_cnt == WaitWidth'(StartupWaitCycles - 1)) begin
            flash_start <= 1'b1;
            state       <= READ;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        READ: if (word_full) state <= WRITE;
        WRITE: if (accepted) begin
          word_addr <= word_addr + 32'd4;
          state     <= (flash_end || flash_done) ? RUN : READ;  // last word
        end
        default: ;  // RUN, host owns the port
      endcase
    end
  end

  // little endian packing, byte 0 ends in [7:0]
  always_ff @(posedge clk) begin
    if (flash_byte_valid) asm_word <= {flash_byte, asm_word[31:8]};
    if (state == READ && word_full) hold_word <= {flash_byte, asm_word[31:8]};
  end

  always_comb begin
    boot_req.enable     = (state == WRITE);  // held until taken
    boot_req.read_type  = RD_NONE;
    boot_req.write_type = WR_W;
    boot_req.address    = word_addr;
    boot_req.data_in    = hold_word;
  end

  // ---------------------------------------
  // port arbitration
  // ---------------------------------------
  assign boot_done = (state == RUN);
  assign mem_req   = boot_done ? host_req : boot_req;

  always_comb begin
    host_rsp = mem_rsp;
    if (!boot_done) begin
      host_rsp.busy           = 1'b1;  // host held off during boot
      host_rsp.data_out_ready = 1'b0;
    end
  end

endmodule

// ==== logic/ramio.sv ====
// ---------------------------------------
// RAM, LED and UART behind one request port
// RAM is 2**RamAddressBitWidth bytes, aliased
// half accesses must be 2 byte aligned
// ---------------------------------------
`timescale 1ns/1ps

module ramio import soc_pkg::*; #(
  parameter int unsigned RamAddressBitWidth = 14,
  parameter int unsigned ClockFrequencyHz   = 27_000_000,
  parameter int unsigned BaudRate           = 115_200
) (
  input  logic       clk,
  input  logic       arst_n,
  input  ramio_req_t req,
  output ramio_rsp_t rsp,
  output logic [3:0] led,
  output logic       uart_tx
);

  localparam int unsigned ClocksPerBit  = ClockFrequencyHz / BaudRate;
  localparam int unsigned WordAddrWidth = RamAddressBitWidth - 2;

  typedef enum logic [1:0] {TGT_RAM, TGT_LED, TGT_UART} target_t;

  logic [31:0]              mem [2**WordAddrWidth];
  logic                     accept;
  logic                     is_read;
  logic                     is_write;
  target_t                  tgt;
  logic [WordAddrWidth-1:0] widx;
  logic [1:0]               off;
  logic [3:0]               be;       // byte lane enables
  logic [31:0]              wdata;    // data copied to every lane
  logic                     acc_busy;
  logic                     rd_ready;
  logic [31:0]              rd_word;
  logic [2:0]               rtype_q;
  logic [1:0]               off_q;
  target_t                  tgt_q;
  logic [31:0]              lane;
  logic [31:0]              ext;
  logic                     tx_busy;
  logic                     tx_tick;
  logic                     tx_send;

  assign accept   = req.enable && !rsp.busy;
  assign is_read  = req.read_type != RD_NONE;
  assign is_write = req.write_type != WR_NONE;
  assign widx     = req.address[RamAddressBitWidth-1:2];
  assign off      = req.address[1:0];

  always_comb begin
    if (req.address == UART_TX_ADDR) tgt = TGT_UART;
    else if (req.address == LED_ADDR) tgt = TGT_LED;
    else tgt = TGT_RAM;
  end

  // ---------------------------------------
  // write lanes
  // ---------------------------------------
  always_comb begin
    case (req.write_type)
      WR_B: begin
        be    = 4'b0001 << off;
        wdata = {4{req.data_in[7:0]}};
      end
      WR_H: begin
        be    = 4'b0011 << {off[1], 1'b0};
        wdata = {2{req.data_in[15:0]}};
      end
      WR_W: begin
        be    = 4'b1111;
        wdata = req.data_in;
      end
      default: begin
        be    = 4'b0000;  // read only
        wdata = req.data_in;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept && tgt == TGT_RAM) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) mem[widx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
    if (accept) begin
      rd_word <= mem[widx];  // old word on a write, unused then
      rtype_q <= req.read_type;
      off_q   <= off;
      tgt_q   <= tgt;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_busy <= 1'b0;
      rd_ready <= 1'b0;
      led      <= '0;
    end else begin
      acc_busy <= accept;  // every access busy one cycle
      rd_ready <= accept && is_read;
      if (accept && is_write && tgt == TGT_LED) led <= req.data_in[3:0];
    end
  end

  // ---------------------------------------
  // read alignment and extension
  // ---------------------------------------
  always_comb begin
    lane = rd_word >> {off_q, 3'b000};
    case (rtype_q)
      RD_B:    ext = {{24{lane[7]}}, lane[7:0]};
      RD_BU:   ext = {24'b0, lane[7:0]};
      RD_H:    ext = {{16{lane[15]}}, lane[15:0]};
      RD_HU:   ext = {16'b0, lane[15:0]};
      default: ext = rd_word;  // word
    endcase
  end

  assign rsp.data_out = (tgt_q == TGT_LED)  ? {28'b0, led} :
                        (tgt_q == TGT_UART) ? 32'b0 : ext;
  assign rsp.data_out_ready = rd_ready;
  assign rsp.busy           = acc_busy || tx_busy;  // uart holds off the port

  assign tx_send = accept && is_write && tgt == TGT_UART;

  baud_timer #(
    .ClocksPerBit(ClocksPerBit)
  ) baud0 (
    .clk,
    .arst_n,
    .run (tx_busy),
    .tick(tx_tick)
  );

  uart_tx tx0 (
    .clk,
    .arst_n,
    .send(tx_send),
    .data(req.data_in[7:0]),
    .tick(tx_tick),
    .uart_tx,
    .busy(tx_busy)
  );

  a_ready_after_read: assert property (@(posedge clk) disable iff (!arst_n)
    rsp.data_out_ready |-> $past(req.enable && !rsp.busy && req.read_type != RD_NONE));

endmodule

// ==== logic/boot_top.sv ====
// ---------------------------------------
// boot and memory I/O subsystem top
// FlashTransferBytes is a multiple of 4 and
// no larger than the RAM
// ---------------------------------------
`timescale 1ns/1ps

module boot_top import soc_pkg::*; #(
  parameter int unsigned RamAddressBitWidth = 14,
  parameter int unsigned StartupWaitCycles  = 1_000_000,
  parameter int unsigned FlashTransferBytes = 4096,
  parameter int unsigned ClockFrequencyHz   = 27_000_000,
  parameter int unsigned BaudRate           = 115_200
) (
  input  logic       clk,
  input  logic       arst_n,
  input  ramio_req_t host_req,
  output ramio_rsp_t host_rsp,
  output logic       boot_done,
  output logic [3:0] led,
  output logic       uart_tx,
  output logic       flash_clk,
  output logic       flash_mosi,
  output logic       flash_cs,
  input  logic       flash_miso
);

  ramio_req_t mem_req;  // loader or host, after the mux
  ramio_rsp_t mem_rsp;
  logic       flash_start;
  logic [7:0] flash_byte;
  logic       flash_byte_valid;
  logic       flash_done;

  boot_loader #(
    .StartupWaitCycles(StartupWaitCycles)
  ) loader0 (
    .clk, .arst_n, .host_req, .host_rsp, .mem_req, .mem_rsp,
    .flash_start, .flash_byte, .flash_byte_valid, .flash_done, .boot_done
  );

  flash_reader #(
    .FlashTransferBytes(FlashTransferBytes)
  ) flash0 (
    .clk, .arst_n, .start(flash_start), .byte_data(flash_byte),
    .byte_valid(flash_byte_valid), .done(flash_done),
    .flash_clk, .flash_mosi, .flash_cs, .flash_miso
  );

  ramio #(
    .RamAddressBitWidth(RamAddressBitWidth),
    .ClockFrequencyHz  (ClockFrequencyHz),
    .BaudRate          (BaudRate)
  ) ramio0 (
    .clk, .arst_n, .req(mem_req), .rsp(mem_rsp), .led, .uart_tx
  );

endmodule

// ==== tb/spi_flash_model.sv ====
// ---------------------------------------
// behavioral SPI flash, mode 0, READ only
// byte at address a reads 3 + 7*a, 8 bits
// the address sent is kept but not decoded
// ---------------------------------------
`timescale 1ns/1ps

module spi_flash_model (
  input  logic        flash_clk,
  input  logic        flash_mosi,
  input  logic        flash_cs,
  output logic        flash_miso,
  output logic [31:0] cmd_word    // opcode and address as received
);

  int unsigned bit_cnt  = 0;    // rising edges since select
  int unsigned data_bit = 0;
  logic [7:0]  cur_byte = '0;
  logic        miso_q   = 1'b0;
  logic [31:0] cmd_sr   = '0;

  assign flash_miso = miso_q;
  assign cmd_word   = cmd_sr;

  // command and address shift in on the rising edge
  always @(posedge flash_clk or posedge flash_cs) begin
    if (flash_cs) begin
      bit_cnt <= 0;  // deselect ends the transfer
    end else begin
      if (bit_cnt < 32) cmd_sr <= {cmd_sr[30:0], flash_mosi};
      bit_cnt <= bit_cnt + 1;
    end
  end

  // data goes out on the falling edge, MSB first
  always @(negedge flash_clk) begin
    if (!flash_cs && bit_cnt >= 32) begin
      data_bit = bit_cnt - 32;               // data bits already clocked
      cur_byte = 8'(3 + 7 * (data_bit / 8));  // byte address is data_bit / 8
      miso_q <= cur_byte[7 - data_bit % 8];
    end
  end

endmodule

// ==== tb/boot_top_tb.sv ====
// ---------------------------------------
// testbench for boot_top, small parameters
// 32 byte flash image, 8 clocks per UART bit
// host port driven on the falling clock edge
// RAM region 0x100 is used for lane tests
// ---------------------------------------
`timescale 1ns/1ps

module boot_top_tb import soc_pkg::*; ();

  localparam int unsigned StartupWait  = 20;
  localparam int unsigned FlashBytes   = 32;
  localparam int unsigned RamBits      = 10;
  localparam int unsigned ClkHz        = 8_000_000;
  localparam int unsigned Baud         = 1_000_000;
  localparam int unsigned ClocksPerBit = 8;  // 8 MHz over 1 Mbaud
  localparam int unsigned Seed         = 15846;
  localparam int unsigned NumUart      = 2;
  localparam int unsigned CycleLimit   = 8 + StartupWait + 2 * (32 + 8 * FlashBytes)
                                         + 10 * ClocksPerBit * NumUart + 1000;
  localparam logic [31:0] FlashCmdExp  = 32'h0300_0000;  // READ opcode, address 0

  // one table row, expected value filled in while the table is built
  typedef struct {
    string       name;
    logic [2:0]  rd;
    logic [1:0]  wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    int          min_wait;  // busy cycles owed before issue
  } entry_t;

  logic        clk;
  logic        arst_n;
  ramio_req_t  host_req;
  ramio_rsp_t  host_rsp;
  logic        boot_done;
  logic [3:0]  led;
  logic        uart_tx;
  logic        flash_clk;
  logic        flash_mosi;
  logic        flash_cs;
  logic        flash_miso;
  logic [31:0] flash_cmd;

  entry_t      table_q[$];
  logic [7:0]  shadow [2**RamBits];  // byte model of the RAM
  logic [3:0]  led_model   = '0;
  logic [7:0]  uart_exp_q[$];        // bytes written, in order
  int          errors      = 0;
  int          rx_errors   = 0;
  int          boot_errors = 0;
  int          rx_count    = 0;
  int          cycles      = 0;

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  boot_top #(
    .RamAddressBitWidth(RamBits),
    .StartupWaitCycles (StartupWait),
    .FlashTransferBytes(FlashBytes),
    .ClockFrequencyHz  (ClkHz),
    .BaudRate          (Baud)
  ) dut0 (
    .clk, .arst_n, .host_req, .host_rsp, .boot_done, .led, .uart_tx,
    .flash_clk, .flash_mosi, .flash_cs, .flash_miso
  );

  spi_flash_model flash_model0 (
    .flash_clk, .flash_mosi, .flash_cs, .flash_miso, .cmd_word(flash_cmd)
  );

  // ---------------------------------------
  // reference model
  // ---------------------------------------
  function automatic logic [7:0] image_byte(int unsigned addr);
    return 8'(3 + 7 * addr);
  endfunction

  function automatic void write_model(logic [31:0] addr, logic [1:0] wr, logic [31:0] data);
    logic [RamBits-1:0] a;
    int                 i;
    a = addr[RamBits-1:0];
    case (wr)
      WR_B: shadow[a] = data[7:0];
      WR_H: begin
        shadow[{a[RamBits-1:1], 1'b0}] = data[7:0];   // low byte at even address
        shadow[{a[RamBits-1:1], 1'b1}] = data[15:8];
      end
      WR_W: begin
        for (i = 0; i < 4; i++) shadow[{a[RamBits-1:2], 2'(i)}] = data[8*i +: 8];
      end
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] read_model(logic [31:0] addr, logic [2:0] rd);
    logic [RamBits-1:0] a;
    logic [7:0]         b;
    logic [15:0]        h;
    a = addr[RamBits-1:0];
    b = shadow[a];
    h = {shadow[{a[RamBits-1:1], 1'b1}], shadow[{a[RamBits-1:1], 1'b0}]};
    case (rd)
      RD_B:    return {{24{b[7]}}, b};
      RD_BU:   return {24'h0, b};
      RD_H:    return {{16{h[15]}}, h};
      RD_HU:   return {16'h0, h};
      default: return {shadow[{a[RamBits-1:2], 2'd3}], shadow[{a[RamBits-1:2], 2'd2}],
                       shadow[{a[RamBits-1:2], 2'd1}], shadow[{a[RamBits-1:2], 2'd0}]};
    endcase
  endfunction

  task automatic add_entry(string name, logic [2:0] rd, logic [1:0] wr,
                           logic [31:0] addr, logic [31:0] data, int min_wait);
    entry_t e;
    e.name     = name;
    e.rd       = rd;
    e.wr       = wr;
    e.addr     = addr;
    e.data     = data;
    e.min_wait = min_wait;
    e.exp      = 32'h0;
    if (addr == LED_ADDR) begin
      if (wr != WR_NONE) led_model = data[3:0];
      e.exp = {28'h0, led_model};  // led after a write, data on a read
    end else if (addr == UART_TX_ADDR) begin
      if (wr != WR_NONE) uart_exp_q.push_back(data[7:0]);
    end else if (wr != WR_NONE) begin
      write_model(addr, wr, data);
    end else begin
      e.exp = read_model(addr, rd);
    end
    table_q.push_back(e);
  endtask

  task automatic build_table();
    int i;
    for (i = 0; i < FlashBytes; i++) shadow[RamBits'(i)] = image_byte(i);
    for (i = 0; i < FlashBytes / 4; i++) begin
      add_entry($sformatf("boot_word_%0d", i), RD_W, WR_NONE, 4 * i, 0, 0);
    end
    for (i = 0; i < 4; i++) begin
      add_entry($sformatf("rand_word_%0d", i), RD_NONE, WR_W, 32'h100 + 4 * i, $urandom(), 0);
    end
    add_entry("byte_neg", RD_NONE, WR_B, 32'h101, $urandom() | 32'h80, 0);  // sign bit set
    add_entry("byte_pos", RD_NONE, WR_B, 32'h10B, $urandom() & 32'h7F, 0);
    add_entry("half_neg", RD_NONE, WR_H, 32'h106, $urandom() | 32'h8000, 0);
    add_entry("half_pos", RD_NONE, WR_H, 32'h108, $urandom() & 32'h7FFF, 0);
    add_entry("rd_b_neg", RD_B, WR_NONE, 32'h101, 0, 0);
    add_entry("rd_bu_neg", RD_BU, WR_NONE, 32'h101, 0, 0);
    add_entry("rd_b_pos", RD_B, WR_NONE, 32'h10B, 0, 0);
    add_entry("rd_bu_lane3", RD_BU, WR_NONE, 32'h103, 0, 0);  // untouched random byte
    add_entry("rd_h_neg", RD_H, WR_NONE, 32'h106, 0, 0);
    add_entry("rd_hu_neg", RD_HU, WR_NONE, 32'h106, 0, 0);
    add_entry("rd_h_pos", RD_H, WR_NONE, 32'h108, 0, 0);
    add_entry("rd_w_0x100", RD_W, WR_NONE, 32'h100, 0, 0);
    add_entry("rd_w_0x104", RD_W, WR_NONE, 32'h104, 0, 0);
    add_entry("rd_w_0x108", RD_W, WR_NONE, 32'h108, 0, 0);
    add_entry("led_write", RD_NONE, WR_W, LED_ADDR, $urandom() | 32'h9, 0);
    add_entry("led_read", RD_W, WR_NONE, LED_ADDR, 0, 0);
    add_entry("uart_first", RD_NONE, WR_B, UART_TX_ADDR, $urandom(), 0);
    add_entry("uart_second", RD_NONE, WR_B, UART_TX_ADDR, $urandom(), 9 * ClocksPerBit);
  endtask

  // ---------------------------------------
  // host side driver
  // ---------------------------------------
  task automatic apply_entry(entry_t e);
    int waited;
    int lat;
    waited = 0;
    while (host_rsp.busy) begin  // sampled mid-cycle, stable here
      @(negedge clk);
      waited++;
    end
    if (waited < e.min_wait) begin
      errors++;
      $display("no back-pressure before %s: busy held for %0d cycles only", e.name, waited);
    end
    host_req.enable     = 1'b1;
    host_req.read_type  = e.rd;
    host_req.write_type = e.wr;
    host_req.address    = e.addr;
    host_req.data_in    = e.data;
    @(negedge clk);  // taken on the edge just passed
    host_req = '0;
    if (e.rd != RD_NONE) begin
      lat = 1;
      while (!host_rsp.data_out_ready && lat < 8) begin
        @(negedge clk);
        lat++;
      end
      if (lat != 1) begin
        errors++;
        $display("read %s gave data_out_ready after %0d cycles instead of 1", e.name, lat);
      end else if (host_rsp.data_out !== e.exp) begin
        errors++;
        $display("mismatch %s: expected %h, actual %h", e.name, e.exp, host_rsp.data_out);
      end
    end else if (e.addr == LED_ADDR && led !== e.exp[3:0]) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", e.name, e.exp[3:0], led);
    end
  endtask

  task automatic check_reset_state(string phase);
    if (host_rsp.busy !== 1'b1 || host_rsp.data_out_ready !== 1'b0 || boot_done !== 1'b0 ||
        uart_tx !== 1'b1 || flash_cs !== 1'b1 || flash_clk !== 1'b0 || led !== 4'h0 ||
        dut0.mem_rsp.busy !== 1'b0) begin
      errors++;
      $display("outputs not in their idle state %s", phase);
    end
  endtask

  // ---------------------------------------
  // main sequence
  // ---------------------------------------
  initial begin
    int unsigned seed_ret;
    arst_n   = 1'b0;
    host_req = '0;
    seed_ret = $urandom(Seed);  // one seed for the whole run
    build_table();
    repeat (4) @(negedge clk);
    check_reset_state("during reset");
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_reset_state("right after reset");
    while (!boot_done) @(negedge clk);
    if (flash_cmd !== FlashCmdExp) begin
      errors++;
      $display("mismatch flash_command: expected %h, actual %h", FlashCmdExp, flash_cmd);
    end
    foreach (table_q[i]) apply_entry(table_q[i]);
    while (rx_count < NumUart) @(negedge clk);  // decoder drains the frames
    $display("errors: host %0d, uart %0d, boot %0d", errors, rx_errors, boot_errors);
    if (errors + rx_errors + boot_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // host port must stay busy until boot_done
  initial begin : boot_monitor
    @(posedge arst_n);
    while (!boot_done) begin
      @(negedge clk);
      if (!boot_done && (host_rsp.busy !== 1'b1 || host_rsp.data_out_ready !== 1'b0)) begin
        boot_errors++;
        $display("host port not held busy while boot_done is low");
      end
    end
  end

  // 8N1 decoder, samples at mid-bit
  initial begin : uart_decoder
    logic [7:0] rx;
    logic [7:0] want;
    int         k;
    forever begin
      @(negedge clk);
      if (arst_n && uart_tx === 1'b0) begin  // start bit edge
        repeat (ClocksPerBit / 2) @(negedge clk);
        if (uart_tx !== 1'b0) begin
          rx_errors++;
          $display("uart start bit did not stay low until mid-bit");
        end
        for (k = 0; k < 8; k++) begin
          repeat (ClocksPerBit) @(negedge clk);
          rx[k] = uart_tx;  // LSB first
        end
        repeat (ClocksPerBit) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          rx_errors++;
          $display("uart stop bit missing after byte %h", rx);
        end
        if (uart_exp_q.size() == 0) begin
          rx_errors++;
          $display("uart byte %h received but none was written", rx);
        end else begin
          want = uart_exp_q.pop_front();
          if (rx !== want) begin
            rx_errors++;
            $display("mismatch uart_byte_%0d: expected %h, actual %h", rx_count, want, rx);
          end
        end
        rx_count++;
      end
    end
  end

  // run limit from boot time, UART frames and margin
  initial begin : watchdog
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", CycleLimit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== rvboot.f ====
logic/soc_pkg.sv
logic/baud_timer.sv
logic/uart_tx.sv
logic/flash_reader.sv
logic/boot_loader.sv
logic/ramio.sv
logic/boot_top.sv
tb/spi_flash_model.sv
tb/boot_top_tb.sv

// ==== Bender.yml ====
package:
  name: rvboot

sources:
  - logic/soc_pkg.sv
  - logic/baud_timer.sv
  - logic/uart_tx.sv
  - logic/flash_reader.sv
  - logic/boot_loader.sv
  - logic/ramio.sv
  - logic/boot_top.sv
  - target: test
    files:
      - tb/spi_flash_model.sv
      - tb/boot_top_tb.sv
